// File: common/cpu_isa_pkg.sv
package cpu_isa_pkg;

    localparam int word_w    = 16;
    localparam int addr_w    = 12;
    localparam int mem_depth = 4096;

    // Instruction word fields
    localparam int i_bit  = 15;
    localparam int op_msb = 14;
    localparam int op_lsb = 12;

    typedef logic [word_w-1:0] word_t;
    typedef logic [addr_w-1:0] addr_t;

    // Opcode field of IR
    typedef enum logic [2:0] {
        AND_OP = 3'd0,
        ADD_OP = 3'd1,
        LDA_OP = 3'd2,
        STA_OP = 3'd3,
        BUN_OP = 3'd4,
        BSA_OP = 3'd5,
        ISZ_OP = 3'd6,
        REG_OP = 3'd7
    } opcode_t;

    // IR bit that selects each register-reference operation
    typedef enum logic [3:0] {
        RR_HLT = 4'd0,
        RR_SZE = 4'd1,
        RR_SZA = 4'd2,
        RR_SNA = 4'd3,
        RR_SPA = 4'd4,
        RR_INC = 4'd5,
        RR_CIL = 4'd6,
        RR_CIR = 4'd7,
        RR_CME = 4'd8,
        RR_CMA = 4'd9,
        RR_CLE = 4'd10,
        RR_CLA = 4'd11
    } rr_bit_e;

endpackage

// File: common/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    // Sequence counter states
    typedef enum logic [2:0] {
        T0, T1, T2, T3, T4, T5, T6
    } t_state_t;

    // Which register drives the internal bus
    typedef enum logic [2:0] {
        BUS_MEM, BUS_AR, BUS_PC, BUS_DR, BUS_AC, BUS_IR
    } bus_src_t;

    typedef enum logic [2:0] {
        ALU_AND, ALU_ADD, ALU_PASS_DR, ALU_CMA, ALU_CIR, ALU_CIL, ALU_HOLD
    } alu_op_t;

    typedef enum logic [1:0] {
        E_HOLD, E_LOAD_ALU, E_CLR, E_CMP
    } e_op_t;

    typedef struct packed {
        logic     ld_ar;
        logic     inc_ar;
        logic     ld_pc;
        logic     inc_pc;
        logic     ld_dr;
        logic     inc_dr;
        logic     ld_ac;
        logic     inc_ac;
        logic     clr_ac;
        logic     ld_ir;
        bus_src_t bus_src;
        alu_op_t  alu_op;
        e_op_t    e_op;
        logic     mem_we;
    } ctrl_word_t;

    // Flags the control unit decides on
    typedef struct packed {
        cpu_isa_pkg::word_t ir;
        logic               ac_sign;
        logic               ac_zero;
        logic               dr_zero;
        logic               e;
    } status_t;

    // Nothing loads, nothing is written
    localparam ctrl_word_t ctrl_idle = '{
        default: 1'b0,
        bus_src: BUS_MEM,
        alu_op:  ALU_HOLD,
        e_op:    E_HOLD
    };

endpackage

// File: control/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  cpu_ctrl_pkg::status_t   status,
    output cpu_ctrl_pkg::ctrl_word_t ctrl,
    output logic                    mem_we,
    output logic                    halted
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    t_state_t sc;
    logic     i_ff;
    logic     run;
    logic     sc_clr;
    logic     hlt_now;
    opcode_t  opcode;

    assign opcode = opcode_t'(status.ir[op_msb:op_lsb]);

    always_comb begin
        ctrl    = ctrl_idle;
        sc_clr  = 1'b0;
        hlt_now = 1'b0;
        if (run) begin
            case (sc)
                T0: begin
                    ctrl.bus_src = BUS_PC;
                    ctrl.ld_ar   = 1'b1;
                end
                T1: begin
                    ctrl.bus_src = BUS_MEM;
                    ctrl.ld_ir   = 1'b1;
                    ctrl.inc_pc  = 1'b1;
                end
                T2: begin
                    ctrl.bus_src = BUS_IR;
                    ctrl.ld_ar   = 1'b1;
                end
                T3: begin
                    if (opcode == REG_OP) begin
                        sc_clr = 1'b1;
                        // Highest set bit wins
                        if (status.ir[RR_CLA]) begin
                            ctrl.clr_ac = 1'b1;
                        end else if (status.ir[RR_CLE]) begin
                            ctrl.e_op = E_CLR;
                        end else if (status.ir[RR_CMA]) begin
                            ctrl.alu_op = ALU_CMA;
                            ctrl.ld_ac  = 1'b1;
                        end else if (status.ir[RR_CME]) begin
                            ctrl.e_op = E_CMP;
                        end else if (status.ir[RR_CIR]) begin
                            ctrl.alu_op = ALU_CIR;
                            ctrl.ld_ac  = 1'b1;
                            ctrl.e_op   = E_LOAD_ALU;
                        end else if (status.ir[RR_CIL]) begin
                            ctrl.alu_op = ALU_CIL;
                            ctrl.ld_ac  = 1'b1;
                            ctrl.e_op   = E_LOAD_ALU;
                        end else if (status.ir[RR_INC]) begin
                            ctrl.inc_ac = 1'b1;
                        end else if (status.ir[RR_SPA]) begin
                            ctrl.inc_pc = !status.ac_sign;
                        end else if (status.ir[RR_SNA]) begin
                            ctrl.inc_pc = status.ac_sign;
                        end else if (status.ir[RR_SZA]) begin
                            ctrl.inc_pc = status.ac_zero;
                        end else if (status.ir[RR_SZE]) begin
                            ctrl.inc_pc = !status.e;
                        end else if (status.ir[RR_HLT]) begin
                            hlt_now = 1'b1;
                        end
                    end else if (i_ff) begin
                        // Indirect: fetch effective address
                        ctrl.bus_src = BUS_MEM;
                        ctrl.ld_ar   = 1'b1;
                    end
                end
                T4: begin
                    case (opcode)
                        AND_OP, ADD_OP, LDA_OP, ISZ_OP: begin
                            ctrl.bus_src = BUS_MEM;
                            ctrl.ld_dr   = 1'b1;
                        end
                        STA_OP: begin
                            ctrl.bus_src = BUS_AC;
                            ctrl.mem_we  = 1'b1;
                            sc_clr       = 1'b1;
                        end
                        BUN_OP: begin
                            ctrl.bus_src = BUS_AR;
                            ctrl.ld_pc   = 1'b1;
                            sc_clr       = 1'b1;
                        end
                        BSA_OP: begin
                            ctrl.bus_src = BUS_PC;
                            ctrl.mem_we  = 1'b1;
                            ctrl.inc_ar  = 1'b1;
                        end
                        default: sc_clr = 1'b1;
                    endcase
                end
                T5: begin
                    sc_clr = 1'b1;
                    case (opcode)
                        AND_OP: begin
                            ctrl.alu_op = ALU_AND;
                            ctrl.ld_ac  = 1'b1;
                        end
                        ADD_OP: begin
                            ctrl.alu_op = ALU_ADD;
                            ctrl.ld_ac  = 1'b1;
                            ctrl.e_op   = E_LOAD_ALU;
                        end
                        LDA_OP: begin
                            ctrl.alu_op = ALU_PASS_DR;
                            ctrl.ld_ac  = 1'b1;
                        end
                        BSA_OP: begin
                            ctrl.bus_src = BUS_AR;
                            ctrl.ld_pc   = 1'b1;
                        end
                        ISZ_OP: begin
                            ctrl.inc_dr = 1'b1;
                            sc_clr      = 1'b0;
                        end
                        default: ;
                    endcase
                end
                T6: begin
                    // Only ISZ gets here
                    ctrl.bus_src = BUS_DR;
                    ctrl.mem_we  = 1'b1;
                    ctrl.inc_pc  = status.dr_zero;
                    sc_clr       = 1'b1;
                end
                default: sc_clr = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sc   <= T0;
            i_ff <= 1'b0;
            run  <= 1'b0;
        end else if (!run) begin
            if (start) begin
                run <= 1'b1;
            end
        end else begin
            if (hlt_now) begin
                run <= 1'b0;
            end
            if (sc_clr) begin
                sc <= T0;
            end else begin
                sc <= t_state_t'(sc + 3'd1);
            end
            if (sc == T2) begin
                i_ff <= status.ir[i_bit];
            end
        end
    end

    assign mem_we = ctrl.mem_we;
    assign halted = !run;

    // Counter never holds the unused code above T6
    sc_range_a: assert property (@(posedge clk) disable iff (rst) sc <= T6)
        else $error("sequence counter passed T6");

    ld_inc_a: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.ld_ar && ctrl.inc_ar) && !(ctrl.ld_pc && ctrl.inc_pc) &&
        !(ctrl.ld_dr && ctrl.inc_dr) && !(ctrl.ld_ac && ctrl.inc_ac))
        else $error("register loaded and incremented together");

    halt_we_a: assert property (@(posedge clk) disable iff (rst) halted |-> !mem_we)
        else $error("memory write while halted");

endmodule

// File: datapath/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic                     clk,
    input  logic                     rst,
    input  cpu_ctrl_pkg::ctrl_word_t ctrl,
    input  cpu_isa_pkg::word_t       rd_data,
    output cpu_isa_pkg::addr_t       ar,
    output cpu_isa_pkg::word_t       bus,
    output cpu_ctrl_pkg::status_t    status,
    output cpu_isa_pkg::addr_t       pc,
    output cpu_isa_pkg::word_t       ac,
    output logic                     e
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    addr_t ar_q;
    addr_t pc_q;
    word_t dr_q;
    word_t ac_q;
    word_t ir_q;
    logic  e_q;
    word_t alu_res;
    logic  alu_carry;

    // Internal bus, addresses are zero-extended
    always_comb begin
        case (ctrl.bus_src)
            BUS_MEM: bus = rd_data;
            BUS_AR:  bus = {{(word_w-addr_w){1'b0}}, ar_q};
            BUS_PC:  bus = {{(word_w-addr_w){1'b0}}, pc_q};
            BUS_DR:  bus = dr_q;
            BUS_AC:  bus = ac_q;
            BUS_IR:  bus = ir_q;
            default: bus = '0;
        endcase
    end

    // ALU with carry toward E
    always_comb begin
        alu_res   = ac_q;
        alu_carry = e_q;
        case (ctrl.alu_op)
            ALU_AND:     alu_res = ac_q & dr_q;
            ALU_ADD:     {alu_carry, alu_res} = {1'b0, ac_q} + {1'b0, dr_q};
            ALU_PASS_DR: alu_res = dr_q;
            ALU_CMA:     alu_res = ~ac_q;
            // Rotates go through E
            ALU_CIR:     {alu_res, alu_carry} = {e_q, ac_q};
            ALU_CIL:     {alu_carry, alu_res} = {ac_q, e_q};
            default:     ;
        endcase
    end

    // Address and data holding registers
    always_ff @(posedge clk) begin
        if (ctrl.ld_ar) begin
            ar_q <= bus[addr_w-1:0];
        end else if (ctrl.inc_ar) begin
            ar_q <= ar_q + 1'b1;
        end
        if (ctrl.ld_dr) begin
            dr_q <= bus;
        end else if (ctrl.inc_dr) begin
            dr_q <= dr_q + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= '0;
            ac_q <= '0;
            ir_q <= '0;
            e_q  <= 1'b0;
        end else begin
            if (ctrl.ld_pc) begin
                pc_q <= bus[addr_w-1:0];
            end else if (ctrl.inc_pc) begin
                pc_q <= pc_q + 1'b1;
            end
            if (ctrl.clr_ac) begin
                ac_q <= '0;
            end else if (ctrl.ld_ac) begin
                ac_q <= alu_res;
            end else if (ctrl.inc_ac) begin
                ac_q <= ac_q + 1'b1;
            end
            if (ctrl.ld_ir) begin
                ir_q <= bus;
            end
            case (ctrl.e_op)
                E_LOAD_ALU: e_q <= alu_carry;
                E_CLR:      e_q <= 1'b0;
                E_CMP:      e_q <= ~e_q;
                default:    ;
            endcase
        end
    end

    assign status.ir      = ir_q;
    assign status.ac_sign = ac_q[word_w-1];
    assign status.ac_zero = (ac_q == '0);
    assign status.dr_zero = (dr_q == '0);
    assign status.e       = e_q;

    assign ar = ar_q;
    assign pc = pc_q;
    assign ac = ac_q;
    assign e  = e_q;

endmodule

// File: source/main_memory.sv
`timescale 1ns/1ps

module main_memory (
    input  logic               clk,
    input  cpu_isa_pkg::addr_t addr,
    input  cpu_isa_pkg::word_t wr_data,
    input  logic               we,
    input  logic               prog_we,
    input  cpu_isa_pkg::addr_t prog_addr,
    input  cpu_isa_pkg::word_t prog_data,
    output cpu_isa_pkg::word_t rd_data
);
    import cpu_isa_pkg::*;

    word_t mem [mem_depth];

    // CPU port first, load port only when the CPU is idle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wr_data;
        end else if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    assign rd_data = mem[addr];

    // Program loading and CPU stores never overlap
    we_excl_a: assert property (@(posedge clk) !(we && prog_we))
        else $error("CPU write and program-load write in the same cycle");

endmodule

// File: source/basic_cpu_top.sv
`timescale 1ns/1ps

module basic_cpu_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               prog_we,
    input  cpu_isa_pkg::addr_t prog_addr,
    input  cpu_isa_pkg::word_t prog_data,
    output logic               halted,
    output cpu_isa_pkg::addr_t pc,
    output cpu_isa_pkg::word_t ac,
    output logic               e
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    ctrl_word_t ctrl;
    status_t    status;
    logic       mem_we;
    addr_t      ar;
    word_t      bus;
    word_t      rd_data;

    control_unit u_ctrl (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .status (status),
        .ctrl   (ctrl),
        .mem_we (mem_we),
        .halted (halted)
    );

    // Memory is addressed by AR and written from the bus
    main_memory u_mem (
        .clk       (clk),
        .addr      (ar),
        .wr_data   (bus),
        .we        (mem_we),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .rd_data   (rd_data)
    );

    datapath u_dp (
        .clk     (clk),
        .rst     (rst),
        .ctrl    (ctrl),
        .rd_data (rd_data),
        .ar      (ar),
        .bus     (bus),
        .status  (status),
        .pc      (pc),
        .ac      (ac),
        .e       (e)
    );

endmodule

// File: tb/tb_basic_cpu.sv
`timescale 1ns/1ps

module tb_basic_cpu;
    import cpu_isa_pkg::*;

    // Instructions over all programs, times 7 cycles, twice, plus load overhead
    localparam int total_instr    = 201;
    localparam int timeout_cycles = total_instr * 7 * 2 + 1000;

    // Data area, well above the program region
    localparam addr_t d_x    = 12'h800;
    localparam addr_t d_y    = 12'h801;
    localparam addr_t d_z    = 12'h802;
    localparam addr_t d_s    = 12'h803;
    localparam addr_t d_ms   = 12'h810;
    localparam addr_t d_mn   = 12'h811;
    localparam addr_t d_val  = 12'h812;
    localparam addr_t d_cnt  = 12'h813;
    localparam addr_t d_ptr0 = 12'h820;
    localparam addr_t d_ptr1 = 12'h821;
    localparam addr_t d_tgt0 = 12'h830;
    localparam addr_t d_tgt1 = 12'h831;

    localparam word_t mark_skip = 16'h5C5C;
    localparam word_t mark_next = 16'h0A0A;
    localparam word_t hlt_word  = 16'h7001;

    logic  clk = 1'b0;
    logic  rst;
    logic  start;
    logic  prog_we;
    addr_t prog_addr;
    word_t prog_data;
    logic  halted;
    addr_t pc;
    word_t ac;
    logic  e;

    word_t       prog [64];
    int          prog_len = 0;
    addr_t       base = '0;
    word_t       exp_ac;
    logic        exp_e;
    logic [31:0] lfsr = 32'he821;
    int          cycles = 0;

    basic_cpu_top DUT (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .halted    (halted),
        .pc        (pc),
        .ac        (ac),
        .e         (e)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: the CPU did not halt within %0d cycles", timeout_cycles);
            $display("TB FAILED");
            $fatal(1, "run stopped by timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // Final state of a program, next program starts where PC stopped
    task automatic check_state(input addr_t exp_pc, input word_t ac_v, input logic e_v);
        check_value("pc", pc, exp_pc);
        check_value("ac", ac, ac_v);
        check_value("e", e, e_v);
        exp_ac = ac_v;
        exp_e  = e_v;
        base   = exp_pc;
    endtask

    function automatic word_t mri(input opcode_t op, input logic ind, input addr_t a);
        return {ind, op, a};
    endfunction

    function automatic word_t rri(input rr_bit_e b);
        return 16'h7000 | (16'h0001 << b);
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output word_t w);
        w = '0;
        for (int k = 0; k < word_w; k++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[word_w-2:0], lfsr[0]};
        end
    endtask

    function automatic addr_t here();
        return base + addr_t'(prog_len);
    endfunction

    task automatic emit(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic load_word(input addr_t a, input word_t d);
        prog_we   = 1'b1;
        prog_addr = a;
        prog_data = d;
        @(posedge clk);
        #1;
        prog_we = 1'b0;
    endtask

    // Load the program at base, start it and wait for the halt
    task automatic run_prog();
        for (int k = 0; k < prog_len; k++) begin
            load_word(base + addr_t'(k), prog[k]);
        end
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_value("halted", halted, 1'b0);
        while (!halted) begin
            @(posedge clk);
            #1;
        end
        prog_len = 0;
    endtask

    task automatic emit_seed(input addr_t a, input logic ev);
        emit(mri(LDA_OP, 1'b0, a));
        emit(rri(RR_CLE));
        if (ev) begin
            emit(rri(RR_CME));
        end
    endtask

    task automatic seed_state(input word_t v, input logic ev);
        addr_t stop;
        load_word(d_val, v);
        emit_seed(d_val, ev);
        emit(hlt_word);
        stop = here();
        run_prog();
        check_state(stop, v, ev);
    endtask

    task automatic rr_model(input rr_bit_e b);
        logic old_e;
        old_e = exp_e;
        case (b)
            RR_CLA: exp_ac = 16'h0000;
            RR_CLE: exp_e = 1'b0;
            RR_CMA: exp_ac = exp_ac ^ 16'hFFFF;
            RR_CME: exp_e = !exp_e;
            RR_CIR: begin
                exp_e  = exp_ac[0];
                exp_ac = {old_e, exp_ac[15:1]};
            end
            RR_CIL: begin
                exp_e  = exp_ac[15];
                exp_ac = {exp_ac[14:0], old_e};
            end
            RR_INC: exp_ac = exp_ac + 16'h0001;
            default: ;
        endcase
    endtask

    task automatic rr_step(input rr_bit_e b);
        emit(rri(b));
        emit(hlt_word);
        run_prog();
        rr_model(b);
        check_state(base + 12'd2, exp_ac, exp_e);
    endtask

    function automatic logic skip_rule(input rr_bit_e b, input word_t acv, input logic ev);
        case (b)
            RR_SPA:  return acv[15] == 1'b0;
            RR_SNA:  return acv[15] == 1'b1;
            RR_SZA:  return acv == 16'h0000;
            RR_SZE:  return ev == 1'b0;
            default: return 1'b0;
        endcase
    endfunction

    // Skipped path loads mark_skip, fall-through path branches to mark_next
    task automatic skip_case(input word_t acv, input logic ev, input word_t instr,
                             input logic taken);
        addr_t stop;
        load_word(d_val, acv);
        emit_seed(d_val, ev);
        emit(instr);
        emit(mri(BUN_OP, 1'b0, here() + 12'd3));
        emit(mri(LDA_OP, 1'b0, d_ms));
        emit(hlt_word);
        emit(mri(LDA_OP, 1'b0, d_mn));
        emit(hlt_word);
        stop = here();
        run_prog();
        if (taken) begin
            check_state(stop - 12'd2, mark_skip, ev);
        end else begin
            check_state(stop, mark_next, ev);
        end
    endtask

    task automatic rr_skip_case(input rr_bit_e b, input word_t acv, input logic ev);
        skip_case(acv, ev, rri(b), skip_rule(b, acv, ev));
    endtask

    task automatic reset_values();
        check_value("halted", halted, 1'b1);
        check_value("pc", pc, 12'h000);
        check_value("ac", ac, 16'h0000);
        check_value("e", e, 1'b0);
        exp_ac = '0;
        exp_e  = 1'b0;
    endtask

    task automatic mem_ref_ops();
        word_t       x;
        word_t       y;
        word_t       z;
        int unsigned sum;
        x = 16'hC3A5;
        y = 16'h7F6B;
        z = 16'h0FF0;
        load_word(d_x, x);
        load_word(d_y, y);
        load_word(d_z, z);
        load_word(d_s, 16'h0000);
        emit(mri(LDA_OP, 1'b0, d_x));
        emit(mri(ADD_OP, 1'b0, d_y));
        emit(mri(AND_OP, 1'b0, d_z));
        emit(mri(STA_OP, 1'b0, d_s));
        emit(rri(RR_CLA));
        emit(mri(LDA_OP, 1'b0, d_s));
        emit(hlt_word);
        run_prog();
        sum = x + y;
        check_state(base + 12'd7, sum[15:0] & z, sum[16]);
    endtask

    task automatic reg_ref_ops();
        seed_state(16'h2D4B, 1'b1);
        rr_step(RR_CLA);
        rr_step(RR_CLE);
        rr_step(RR_CMA);
        rr_step(RR_CME);
        rr_step(RR_CIR);
        rr_step(RR_CIL);
        rr_step(RR_INC);
        // Uneven pattern so the rotates show up
        seed_state(16'hA5C3, 1'b0);
        rr_step(RR_CIR);
        rr_step(RR_CIR);
        rr_step(RR_CIL);
        rr_step(RR_CME);
        rr_step(RR_CIL);
        rr_step(RR_INC);
    endtask

    task automatic branch_skip();
        addr_t sub;
        load_word(d_ms, mark_skip);
        load_word(d_mn, mark_next);
        // Jump over the mark_next load and its halt
        emit(mri(BUN_OP, 1'b0, here() + 12'd3));
        emit(mri(LDA_OP, 1'b0, d_mn));
        emit(hlt_word);
        emit(mri(LDA_OP, 1'b0, d_ms));
        emit(hlt_word);
        run_prog();
        check_state(base + 12'd5, mark_skip, exp_e);
        // Return address lands in the slot, execution continues after it
        sub = here() + 12'd2;
        emit(mri(BSA_OP, 1'b0, sub));
        emit(hlt_word);
        emit(16'h0000);
        emit(mri(LDA_OP, 1'b0, sub));
        emit(hlt_word);
        run_prog();
        check_state(base + 12'd5, {4'h0, sub - 12'd1}, exp_e);
        load_word(d_cnt, 16'hFFFF);
        skip_case(16'h0001, 1'b0, mri(ISZ_OP, 1'b0, d_cnt), 1'b1);
        emit(mri(LDA_OP, 1'b0, d_cnt));
        emit(hlt_word);
        run_prog();
        check_state(base + 12'd2, 16'h0000, 1'b0);
        load_word(d_cnt, 16'h7FFE);
        skip_case(16'h0001, 1'b1, mri(ISZ_OP, 1'b0, d_cnt), 1'b0);
        rr_skip_case(RR_SPA, 16'h1234, 1'b0);
        rr_skip_case(RR_SPA, 16'h8001, 1'b0);
        rr_skip_case(RR_SNA, 16'h8001, 1'b1);
        rr_skip_case(RR_SNA, 16'h1234, 1'b1);
        rr_skip_case(RR_SZA, 16'h0000, 1'b0);
        rr_skip_case(RR_SZA, 16'h1234, 1'b0);
        rr_skip_case(RR_SZE, 16'h1234, 1'b0);
        rr_skip_case(RR_SZE, 16'h1234, 1'b1);
    endtask

    task automatic indirect_addr();
        load_word(d_ptr0, {4'h0, d_tgt0});
        load_word(d_ptr1, {4'h0, d_tgt1});
        load_word(d_tgt0, 16'h3C5A);
        load_word(d_tgt1, 16'h0000);
        emit(mri(LDA_OP, 1'b1, d_ptr0));
        emit(mri(STA_OP, 1'b1, d_ptr1));
        emit(rri(RR_CLA));
        emit(mri(LDA_OP, 1'b0, d_tgt1));
        emit(hlt_word);
        run_prog();
        check_state(base + 12'd5, 16'h3C5A, exp_e);
    endtask

    task automatic random_alu();
        word_t       x;
        word_t       y;
        int unsigned sum;
        for (int n = 0; n < 10; n++) begin
            rand_word(x);
            rand_word(y);
            load_word(d_x, x);
            load_word(d_y, y);
            emit(mri(LDA_OP, 1'b0, d_x));
            emit(mri(ADD_OP, 1'b0, d_y));
            emit(hlt_word);
            run_prog();
            sum = x + y;
            check_state(base + 12'd3, sum[15:0], sum[16]);
            // AND leaves E as the ADD set it
            emit(mri(LDA_OP, 1'b0, d_x));
            emit(mri(AND_OP, 1'b0, d_y));
            emit(hlt_word);
            run_prog();
            check_state(base + 12'd3, x & y, exp_e);
        end
    endtask

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_values();
        mem_ref_ops();
        reg_ref_ops();
        branch_skip();
        indirect_addr();
        random_alu();
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: sources.f
common/cpu_isa_pkg.sv
common/cpu_ctrl_pkg.sv
control/control_unit.sv
datapath/datapath.sv
source/main_memory.sv
source/basic_cpu_top.sv
tb/tb_basic_cpu.sv

// File: Bender.yml
package:
  name: basic_cpu

sources:
  - files:
      # Packages first
      - common/cpu_isa_pkg.sv
      - common/cpu_ctrl_pkg.sv
      # Design
      - control/control_unit.sv
      - datapath/datapath.sv
      - source/main_memory.sv
      - source/basic_cpu_top.sv

  - target: test
    files:
      - tb/tb_basic_cpu.sv
